//--- clint_pkg.sv
package clint_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;

  typedef logic [AXI_ID_W-1:0] axi_tid_t;
  typedef logic [1:0]          axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  // Regions are told apart by address bits 31:16
  localparam logic [AXI_ADDR_W-1:0] MTIMER_BASE = 32'h0000_0000;
  localparam logic [AXI_ADDR_W-1:0] MSIP_BASE   = 32'h0001_0000;

  // Timer register offsets
  localparam logic [15:0] MTIME_LO    = 16'h0000;
  localparam logic [15:0] MTIME_HI    = 16'h0004;
  localparam logic [15:0] MTIMECMP_LO = 16'h0008;
  localparam logic [15:0] MTIMECMP_HI = 16'h000C;

  // Single msip bit at the bottom of its region
  localparam logic [15:0] MSIP_REG = 16'h0000;

  localparam int MTIME_DIV     = 4;
  localparam int MTIME_PRESC_W = $clog2(MTIME_DIV);

  typedef struct packed {
    axi_tid_t  id;
    axi_resp_t resp;
  } b_payload_t;

  typedef struct packed {
    axi_tid_t                id;
    logic [AXI_DATA_W-1:0]   data;
    axi_resp_t               resp;
  } r_payload_t;

endpackage

//--- resp_hold.sv
`timescale 1ns/1ps

module resp_hold #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Room when empty or when the held entry leaves this cycle
  assign in_ready  = ~full | out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

//--- axi_mtimer.sv
`timescale 1ns/1ps

module axi_mtimer import clint_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // AW
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  axi_tid_t              awid,
  // W
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  // B
  output logic                  bvalid,
  input  logic                  bready,
  output axi_tid_t              bid,
  output axi_resp_t             bresp,
  // AR
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  axi_tid_t              arid,
  // R
  output logic                  rvalid,
  input  logic                  rready,
  output axi_tid_t              rid,
  output logic [AXI_DATA_W-1:0] rdata,
  output axi_resp_t             rresp,
  output logic                  mtimer_irq
);

  logic [MTIME_PRESC_W-1:0] presc;
  logic [63:0]              mtime;
  logic [63:0]              mtimecmp;
  logic                     aw_pend;
  logic [15:0]              wr_off;
  axi_tid_t                 wr_id;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     b_in_ready;
  logic [AXI_DATA_W-1:0]    rd_data;
  b_payload_t               b_in;
  b_payload_t               b_out;
  r_payload_t               r_in;
  r_payload_t               r_out;

  // One write at a time, W only after its AW
  assign awready = ~aw_pend;
  assign wready  = aw_pend & b_in_ready;
  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      presc    <= '0;
      mtime    <= '0;
      mtimecmp <= '1;
      aw_pend  <= 1'b0;
    end else begin
      if (presc == MTIME_PRESC_W'(MTIME_DIV - 1)) begin
        presc <= '0;
        mtime <= mtime + 64'd1;
      end else begin
        presc <= presc + 1'b1;
      end

      if (aw_fire) begin
        aw_pend <= 1'b1;
      end else if (w_fire) begin
        aw_pend <= 1'b0;
      end

      // mtime itself is read only
      if (w_fire) begin
        case (wr_off)
          MTIMECMP_LO: mtimecmp[31:0]  <= wdata;
          MTIMECMP_HI: mtimecmp[63:32] <= wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_off <= awaddr[15:0];
      wr_id  <= awid;
    end
  end

  // Sampled in the AR cycle
  always_comb begin
    case (araddr[15:0])
      MTIME_LO:    rd_data = mtime[31:0];
      MTIME_HI:    rd_data = mtime[63:32];
      MTIMECMP_LO: rd_data = mtimecmp[31:0];
      MTIMECMP_HI: rd_data = mtimecmp[63:32];
      default:     rd_data = '0;
    endcase
  end

  assign b_in = '{id: wr_id, resp: RESP_OKAY};
  assign r_in = '{id: arid, data: rd_data, resp: RESP_OKAY};

  resp_hold #(.payload_t(b_payload_t)) u_b_hold (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (w_fire),
    .in_ready  (b_in_ready),
    .in_data   (b_in),
    .out_valid (bvalid),
    .out_ready (bready),
    .out_data  (b_out)
  );

  resp_hold #(.payload_t(r_payload_t)) u_r_hold (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (arvalid),
    .in_ready  (arready),
    .in_data   (r_in),
    .out_valid (rvalid),
    .out_ready (rready),
    .out_data  (r_out)
  );

  assign bid   = b_out.id;
  assign bresp = b_out.resp;
  assign rid   = r_out.id;
  assign rdata = r_out.data;
  assign rresp = r_out.resp;

  assign mtimer_irq = (mtime >= mtimecmp);

endmodule

//--- axi_msip.sv
`timescale 1ns/1ps

module axi_msip import clint_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  axi_tid_t              awid,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output axi_tid_t              bid,
  output axi_resp_t             bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  axi_tid_t              arid,
  output logic                  rvalid,
  input  logic                  rready,
  output axi_tid_t              rid,
  output logic [AXI_DATA_W-1:0] rdata,
  output axi_resp_t             rresp,
  output logic                  msip_irq
);

  logic       msip;
  logic       aw_pend;
  logic       wr_hit;
  axi_tid_t   wr_id;
  logic       aw_fire;
  logic       w_fire;
  logic       b_in_ready;
  b_payload_t b_in;
  b_payload_t b_out;
  r_payload_t r_in;
  r_payload_t r_out;

  assign awready = ~aw_pend;
  assign wready  = aw_pend & b_in_ready;
  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      msip    <= 1'b0;
      aw_pend <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_pend <= 1'b1;
      end else if (w_fire) begin
        aw_pend <= 1'b0;
      end
      if (w_fire && wr_hit) begin
        msip <= wdata[0];
      end
    end
  end

  // Other offsets take the write and drop it
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_hit <= (awaddr[15:0] == MSIP_REG);
      wr_id  <= awid;
    end
  end

  assign b_in = '{id: wr_id, resp: RESP_OKAY};
  assign r_in = '{id: arid,
                  data: (araddr[15:0] == MSIP_REG) ? AXI_DATA_W'(msip) : '0,
                  resp: RESP_OKAY};

  resp_hold #(.payload_t(b_payload_t)) u_b_hold (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (w_fire),
    .in_ready  (b_in_ready),
    .in_data   (b_in),
    .out_valid (bvalid),
    .out_ready (bready),
    .out_data  (b_out)
  );

  resp_hold #(.payload_t(r_payload_t)) u_r_hold (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (arvalid),
    .in_ready  (arready),
    .in_data   (r_in),
    .out_valid (rvalid),
    .out_ready (rready),
    .out_data  (r_out)
  );

  assign bid   = b_out.id;
  assign bresp = b_out.resp;
  assign rid   = r_out.id;
  assign rdata = r_out.data;
  assign rresp = r_out.resp;

  assign msip_irq = msip;

endmodule

//--- clint_demux.sv
`timescale 1ns/1ps

module clint_demux import clint_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // Upstream slave port
  input  logic                  awvalid, wvalid, bready, arvalid, rready,
  output logic                  awready, wready, bvalid, arready, rvalid, rlast,
  input  logic [AXI_ADDR_W-1:0] awaddr, araddr,
  input  axi_tid_t              awid, arid,
  input  logic [AXI_DATA_W-1:0] wdata,
  output axi_tid_t              bid, rid,
  output axi_resp_t             bresp, rresp,
  output logic [AXI_DATA_W-1:0] rdata,
  // Toward the timer
  output logic                  mt_awvalid, mt_wvalid, mt_bready, mt_arvalid, mt_rready,
  input  logic                  mt_awready, mt_wready, mt_bvalid, mt_arready, mt_rvalid,
  output logic [AXI_ADDR_W-1:0] mt_awaddr, mt_araddr,
  output axi_tid_t              mt_awid, mt_arid,
  output logic [AXI_DATA_W-1:0] mt_wdata,
  input  axi_tid_t              mt_bid, mt_rid,
  input  axi_resp_t             mt_bresp, mt_rresp,
  input  logic [AXI_DATA_W-1:0] mt_rdata,
  // Toward msip
  output logic                  ms_awvalid, ms_wvalid, ms_bready, ms_arvalid, ms_rready,
  input  logic                  ms_awready, ms_wready, ms_bvalid, ms_arready, ms_rvalid,
  output logic [AXI_ADDR_W-1:0] ms_awaddr, ms_araddr,
  output axi_tid_t              ms_awid, ms_arid,
  output logic [AXI_DATA_W-1:0] ms_wdata,
  input  axi_tid_t              ms_bid, ms_rid,
  input  axi_resp_t             ms_bresp, ms_rresp,
  input  logic [AXI_DATA_W-1:0] ms_rdata
);

  typedef enum logic [1:0] {TGT_NONE, TGT_MT, TGT_MS} tgt_t;

  logic     rdy_en;
  logic     wr_pend, rd_pend;
  tgt_t     wr_tgt, rd_tgt;
  tgt_t     aw_tgt, ar_tgt;
  logic     aw_open, ar_open;
  logic     aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic     err_bvalid, err_rvalid;
  axi_tid_t err_bid, err_rid;

  function automatic tgt_t decode(input logic [AXI_ADDR_W-1:0] addr);
    if (addr[AXI_ADDR_W-1:16] == MTIMER_BASE[AXI_ADDR_W-1:16]) begin
      return TGT_MT;
    end else if (addr[AXI_ADDR_W-1:16] == MSIP_BASE[AXI_ADDR_W-1:16]) begin
      return TGT_MS;
    end
    return TGT_NONE;
  endfunction

  assign aw_tgt  = decode(awaddr);
  assign ar_tgt  = decode(araddr);
  // Closed for one cycle after reset and while a request is in flight
  assign aw_open = rdy_en & ~wr_pend;
  assign ar_open = rdy_en & ~rd_pend;

  assign mt_awvalid = awvalid & aw_open & (aw_tgt == TGT_MT);
  assign ms_awvalid = awvalid & aw_open & (aw_tgt == TGT_MS);
  assign mt_awaddr  = awaddr;
  assign ms_awaddr  = awaddr;
  assign mt_awid    = awid;
  assign ms_awid    = awid;

  assign mt_arvalid = arvalid & ar_open & (ar_tgt == TGT_MT);
  assign ms_arvalid = arvalid & ar_open & (ar_tgt == TGT_MS);
  assign mt_araddr  = araddr;
  assign ms_araddr  = araddr;
  assign mt_arid    = arid;
  assign ms_arid    = arid;

  // W follows the registered write target
  assign mt_wvalid = wvalid & wr_pend & (wr_tgt == TGT_MT);
  assign ms_wvalid = wvalid & wr_pend & (wr_tgt == TGT_MS);
  assign mt_wdata  = wdata;
  assign ms_wdata  = wdata;

  assign mt_bready = bready & wr_pend & (wr_tgt == TGT_MT);
  assign ms_bready = bready & wr_pend & (wr_tgt == TGT_MS);
  assign mt_rready = rready & rd_pend & (rd_tgt == TGT_MT);
  assign ms_rready = rready & rd_pend & (rd_tgt == TGT_MS);

  always_comb begin
    case (aw_tgt)
      TGT_MT:  awready = aw_open & mt_awready;
      TGT_MS:  awready = aw_open & ms_awready;
      default: awready = aw_open;
    endcase
    case (ar_tgt)
      TGT_MT:  arready = ar_open & mt_arready;
      TGT_MS:  arready = ar_open & ms_arready;
      default: arready = ar_open;
    endcase
  end

  always_comb begin
    case (wr_tgt)
      TGT_MT: begin
        wready = wr_pend & mt_wready;
        bvalid = wr_pend & mt_bvalid;
        bid    = mt_bid;
        bresp  = mt_bresp;
      end
      TGT_MS: begin
        wready = wr_pend & ms_wready;
        bvalid = wr_pend & ms_bvalid;
        bid    = ms_bid;
        bresp  = ms_bresp;
      end
      default: begin
        wready = wr_pend & ~err_bvalid;
        bvalid = err_bvalid;
        bid    = err_bid;
        bresp  = RESP_DECERR;
      end
    endcase
  end

  always_comb begin
    case (rd_tgt)
      TGT_MT: begin
        rvalid = rd_pend & mt_rvalid;
        rid    = mt_rid;
        rdata  = mt_rdata;
        rresp  = mt_rresp;
      end
      TGT_MS: begin
        rvalid = rd_pend & ms_rvalid;
        rid    = ms_rid;
        rdata  = ms_rdata;
        rresp  = ms_rresp;
      end
      default: begin
        rvalid = err_rvalid;
        rid    = err_rid;
        rdata  = '0;
        rresp  = RESP_DECERR;
      end
    endcase
  end

  assign rlast   = rvalid;
  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign b_fire  = bvalid & bready;
  assign ar_fire = arvalid & arready;
  assign r_fire  = rvalid & rready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rdy_en     <= 1'b0;
      wr_pend    <= 1'b0;
      rd_pend    <= 1'b0;
      wr_tgt     <= TGT_NONE;
      rd_tgt     <= TGT_NONE;
      err_bvalid <= 1'b0;
      err_rvalid <= 1'b0;
    end else begin
      rdy_en <= 1'b1;
      if (aw_fire) begin
        wr_pend <= 1'b1;
        wr_tgt  <= aw_tgt;
      end else if (b_fire) begin
        wr_pend <= 1'b0;
      end
      if (ar_fire) begin
        rd_pend <= 1'b1;
        rd_tgt  <= ar_tgt;
      end else if (r_fire) begin
        rd_pend <= 1'b0;
      end
      // Local error responses for unmapped addresses
      if (w_fire && wr_tgt == TGT_NONE) begin
        err_bvalid <= 1'b1;
      end else if (b_fire) begin
        err_bvalid <= 1'b0;
      end
      if (ar_fire && ar_tgt == TGT_NONE) begin
        err_rvalid <= 1'b1;
      end else if (r_fire) begin
        err_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      err_bid <= awid;
    end
    if (ar_fire) begin
      err_rid <= arid;
    end
  end

endmodule

//--- clint_top.sv
`timescale 1ns/1ps

module clint_top import clint_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  axi_tid_t              awid,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output axi_tid_t              bid,
  output axi_resp_t             bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  axi_tid_t              arid,
  output logic                  rvalid,
  input  logic                  rready,
  output axi_tid_t              rid,
  output logic [AXI_DATA_W-1:0] rdata,
  output axi_resp_t             rresp,
  output logic                  rlast,
  output logic                  mtimer_irq,
  output logic                  msip_irq
);

  logic                  mt_awvalid, mt_wvalid, mt_bready, mt_arvalid, mt_rready;
  logic                  mt_awready, mt_wready, mt_bvalid, mt_arready, mt_rvalid;
  logic [AXI_ADDR_W-1:0] mt_awaddr, mt_araddr;
  axi_tid_t              mt_awid, mt_arid, mt_bid, mt_rid;
  logic [AXI_DATA_W-1:0] mt_wdata, mt_rdata;
  axi_resp_t             mt_bresp, mt_rresp;

  logic                  ms_awvalid, ms_wvalid, ms_bready, ms_arvalid, ms_rready;
  logic                  ms_awready, ms_wready, ms_bvalid, ms_arready, ms_rvalid;
  logic [AXI_ADDR_W-1:0] ms_awaddr, ms_araddr;
  axi_tid_t              ms_awid, ms_arid, ms_bid, ms_rid;
  logic [AXI_DATA_W-1:0] ms_wdata, ms_rdata;
  axi_resp_t             ms_bresp, ms_rresp;

  clint_demux u_demux (.*);

  axi_mtimer u_mtimer (
    .clk (clk), .rst (rst),
    .awvalid (mt_awvalid), .awready (mt_awready), .awaddr (mt_awaddr), .awid (mt_awid),
    .wvalid  (mt_wvalid),  .wready  (mt_wready),  .wdata  (mt_wdata),
    .bvalid  (mt_bvalid),  .bready  (mt_bready),  .bid    (mt_bid),    .bresp (mt_bresp),
    .arvalid (mt_arvalid), .arready (mt_arready), .araddr (mt_araddr), .arid  (mt_arid),
    .rvalid  (mt_rvalid),  .rready  (mt_rready),  .rid    (mt_rid),
    .rdata   (mt_rdata),   .rresp   (mt_rresp),
    .mtimer_irq (mtimer_irq)
  );

  axi_msip u_msip (
    .clk (clk), .rst (rst),
    .awvalid (ms_awvalid), .awready (ms_awready), .awaddr (ms_awaddr), .awid (ms_awid),
    .wvalid  (ms_wvalid),  .wready  (ms_wready),  .wdata  (ms_wdata),
    .bvalid  (ms_bvalid),  .bready  (ms_bready),  .bid    (ms_bid),    .bresp (ms_bresp),
    .arvalid (ms_arvalid), .arready (ms_arready), .araddr (ms_araddr), .arid  (ms_arid),
    .rvalid  (ms_rvalid),  .rready  (ms_rready),  .rid    (ms_rid),
    .rdata   (ms_rdata),   .rresp   (ms_rresp),
    .msip_irq (msip_irq)
  );

endmodule

//--- clint_checker.sv
`timescale 1ns/1ps

module clint_checker import clint_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  awvalid,
  input  logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  axi_tid_t              awid,
  input  logic                  wvalid,
  input  logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic                  bvalid,
  input  logic                  bready,
  input  axi_tid_t              bid,
  input  axi_resp_t             bresp,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  axi_tid_t              arid,
  input  logic                  rvalid,
  input  logic                  rready,
  input  axi_tid_t              rid,
  input  logic [AXI_DATA_W-1:0] rdata,
  input  axi_resp_t             rresp,
  input  logic                  rlast,
  input  logic                  mtimer_irq,
  input  logic                  msip_irq,
  input  int                    test_id,
  input  logic                  test_end,
  output int                    errors,
  output int                    checks
);

  logic [63:0]           cyc;
  logic [63:0]           cmp_model;
  logic                  msip_model;
  logic [AXI_ADDR_W-1:0] wr_addr;
  axi_tid_t              wr_id;
  axi_tid_t              rd_id;
  axi_resp_t             rd_resp;
  logic [AXI_DATA_W-1:0] rd_exp;
  logic                  rd_time;
  logic                  rd_hi;
  logic [63:0]           rd_bound;
  logic [63:0]           last_time;
  logic [63:0]           seen_time;
  logic                  exp_mt;
  logic                  mt_bad;
  logic                  ms_bad;
  int                    test_errors;
  int                    test_checks;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_values";
      2:       return "write_readback";
      3:       return "mtime_reads";
      4:       return "timer_irq";
      5:       return "msip_irq";
      6:       return "decode_error";
      default: return "idle";
    endcase
  endfunction

  // 0 timer, 1 msip, 2 unmapped
  function automatic int region_of(input logic [AXI_ADDR_W-1:0] addr);
    if (addr[31:16] == MTIMER_BASE[31:16]) begin
      return 0;
    end else if (addr[31:16] == MSIP_BASE[31:16]) begin
      return 1;
    end
    return 2;
  endfunction

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name(test_id), what, exp, act);
    end
  endtask

  task automatic check_range(input string what, input logic [63:0] lo, input logic [63:0] hi,
                             input logic [63:0] act);
    checks++;
    test_checks++;
    if (act < lo || act > hi) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s %s: expected %0d..%0d, actual %0d",
               test_name(test_id), what, lo, hi, act);
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      cyc         = '0;
      cmp_model   = '1;
      msip_model  = 1'b0;
      last_time   = '0;
      mt_bad      = 1'b0;
      ms_bad      = 1'b0;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      test_checks = 0;
    end else begin
      // Interrupts are compared every cycle
      exp_mt = (cyc / MTIME_DIV) >= cmp_model;
      if (mtimer_irq !== exp_mt) begin
        if (!mt_bad) begin
          errors++;
          test_errors++;
          $display("[FAIL] %s mtimer_irq: expected %0d, actual %0d",
                   test_name(test_id), exp_mt, mtimer_irq);
        end
        mt_bad = 1'b1;
      end else begin
        mt_bad = 1'b0;
      end
      if (msip_irq !== msip_model) begin
        if (!ms_bad) begin
          errors++;
          test_errors++;
          $display("[FAIL] %s msip_irq: expected %0d, actual %0d",
                   test_name(test_id), msip_model, msip_irq);
        end
        ms_bad = 1'b1;
      end else begin
        ms_bad = 1'b0;
      end

      if (rvalid && rready) begin
        check_eq("rid", rd_id, rid);
        check_eq("rresp", rd_resp, rresp);
        check_eq("rlast", 1, rlast);
        if (rd_time) begin
          seen_time = rd_hi ? {rdata, last_time[31:0]} : {last_time[63:32], rdata};
          check_range("mtime", last_time, rd_bound, seen_time);
          last_time = seen_time;
        end else begin
          check_eq("rdata", rd_exp, rdata);
        end
      end

      if (bvalid && bready) begin
        check_eq("bid", wr_id, bid);
        check_eq("bresp", (region_of(wr_addr) == 2) ? RESP_DECERR : RESP_OKAY, bresp);
      end

      // Expected read data is the model value in the AR cycle
      if (arvalid && arready) begin
        rd_id    = arid;
        rd_resp  = RESP_OKAY;
        rd_exp   = '0;
        rd_time  = 1'b0;
        rd_hi    = (araddr[15:0] == MTIME_HI);
        rd_bound = cyc / MTIME_DIV;
        case (region_of(araddr))
          0: begin
            case (araddr[15:0])
              MTIME_LO, MTIME_HI: rd_time = 1'b1;
              MTIMECMP_LO:        rd_exp  = cmp_model[31:0];
              MTIMECMP_HI:        rd_exp  = cmp_model[63:32];
              default: ;
            endcase
          end
          1: begin
            if (araddr[15:0] == MSIP_REG) begin
              rd_exp = {31'b0, msip_model};
            end
          end
          default: rd_resp = RESP_DECERR;
        endcase
      end

      if (awvalid && awready) begin
        wr_addr = awaddr;
        wr_id   = awid;
      end

      if (wvalid && wready) begin
        if (region_of(wr_addr) == 0) begin
          if (wr_addr[15:0] == MTIMECMP_LO) begin
            cmp_model[31:0] = wdata;
          end else if (wr_addr[15:0] == MTIMECMP_HI) begin
            cmp_model[63:32] = wdata;
          end
        end else if (region_of(wr_addr) == 1 && wr_addr[15:0] == MSIP_REG) begin
          msip_model = wdata[0];
        end
      end

      if (test_end) begin
        if (test_errors == 0) begin
          $display("test %s: ok, %0d checks", test_name(test_id), test_checks);
        end else begin
          $display("test %s: %0d errors in %0d checks",
                   test_name(test_id), test_errors, test_checks);
        end
        test_errors = 0;
        test_checks = 0;
      end

      cyc = cyc + 64'd1;
    end
  end

endmodule

//--- clint_props.sv
`timescale 1ns/1ps

module clint_props import clint_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  awvalid,
  input logic                  awready,
  input logic [AXI_ADDR_W-1:0] awaddr,
  input axi_tid_t              awid,
  input logic                  wvalid,
  input logic                  wready,
  input logic [AXI_DATA_W-1:0] wdata,
  input logic                  bvalid,
  input logic                  bready,
  input axi_tid_t              bid,
  input axi_resp_t             bresp,
  input logic                  arvalid,
  input logic                  arready,
  input logic [AXI_ADDR_W-1:0] araddr,
  input axi_tid_t              arid,
  input logic                  rvalid,
  input logic                  rready,
  input axi_tid_t              rid,
  input logic [AXI_DATA_W-1:0] rdata,
  input axi_resp_t             rresp,
  input logic                  rlast
);

  // Set by a W transfer, cleared by the matching B transfer
  logic w_open;

  always_ff @(posedge clk) begin
    if (!rst) begin
      w_open <= 1'b0;
    end else if (wvalid && wready) begin
      w_open <= 1'b1;
    end else if (bvalid && bready) begin
      w_open <= 1'b0;
    end
  end

  aw_stable: assert property (@(posedge clk) disable iff (!rst)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
    else $error("AW valid or payload changed before the transfer");

  w_stable: assert property (@(posedge clk) disable iff (!rst)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("W valid or payload changed before the transfer");

  b_stable: assert property (@(posedge clk) disable iff (!rst)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else $error("B valid or payload changed before the transfer");

  ar_stable: assert property (@(posedge clk) disable iff (!rst)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
    else $error("AR valid or payload changed before the transfer");

  r_stable: assert property (@(posedge clk) disable iff (!rst)
    rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rresp))
    else $error("R valid or payload changed before the transfer");

  rlast_match: assert property (@(posedge clk) disable iff (!rst) rlast == rvalid)
    else $error("rlast differs from rvalid");

  b_after_w: assert property (@(posedge clk) disable iff (!rst) bvalid |-> w_open)
    else $error("bvalid without a preceding W transfer");

endmodule

bind clint_top clint_props u_props (.*);

//--- tb_clint.sv
`timescale 1ns/1ps

module tb_clint import clint_pkg::*; ();

  logic                  clk;
  logic                  rst;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_ADDR_W-1:0] awaddr;
  axi_tid_t              awid;
  logic                  wvalid;
  logic                  wready;
  logic [AXI_DATA_W-1:0] wdata;
  logic                  bvalid;
  logic                  bready;
  axi_tid_t              bid;
  axi_resp_t             bresp;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_ADDR_W-1:0] araddr;
  axi_tid_t              arid;
  logic                  rvalid;
  logic                  rready;
  axi_tid_t              rid;
  logic [AXI_DATA_W-1:0] rdata;
  axi_resp_t             rresp;
  logic                  rlast;
  logic                  mtimer_irq;
  logic                  msip_irq;
  int                    test_id;
  logic                  test_end;
  int                    errors;
  int                    checks;

  logic [63:0]           lcg_state;
  int                    tb_errors;
  logic                  hung;
  logic [31:0]           rnd;
  logic [31:0]           rval;
  logic [31:0]           addr;
  int                    n;

  clint_top u_dut (.*);

  clint_checker u_chk (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function automatic logic [31:0] timer_addr(input logic [15:0] off);
    return MTIMER_BASE | {16'h0, off};
  endfunction

  function automatic logic [31:0] msip_addr(input logic [15:0] off);
    return MSIP_BASE | {16'h0, off};
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  task automatic start_test(input int id);
    test_id <= id;
  endtask

  task automatic end_test();
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  task automatic axi_write(input logic [31:0] wr_addr, input logic [31:0] wr_data);
    logic [31:0] r;
    logic        done;
    int          cnt;
    if (hung) return;
    r = next_rand();
    awvalid <= 1'b1;
    awaddr  <= wr_addr;
    awid    <= r[3:0];
    wvalid  <= 1'b1;
    wdata   <= wr_data;
    bready  <= r[4] | r[5];
    done = 1'b0;
    cnt  = 0;
    while (!done && cnt < 200) begin
      @(posedge clk);
      cnt++;
      if (awvalid && awready) awvalid <= 1'b0;
      if (wvalid && wready) wvalid <= 1'b0;
      if (bvalid && bready) begin
        done = 1'b1;
        bready <= 1'b0;
      end else begin
        // Random back-pressure on B
        r = next_rand();
        bready <= r[0] | r[1];
      end
    end
    if (!done) begin
      $display("timeout: write to %h got no response within %0d cycles", wr_addr, cnt);
      tb_errors++;
      hung = 1'b1;
    end
  endtask

  task automatic axi_read(input logic [31:0] rd_addr, output logic [31:0] rd_data);
    logic [31:0] r;
    logic        done;
    int          cnt;
    rd_data = '0;
    if (hung) return;
    r = next_rand();
    arvalid <= 1'b1;
    araddr  <= rd_addr;
    arid    <= r[3:0];
    rready  <= r[4] | r[5];
    done = 1'b0;
    cnt  = 0;
    while (!done && cnt < 200) begin
      @(posedge clk);
      cnt++;
      if (arvalid && arready) arvalid <= 1'b0;
      if (rvalid && rready) begin
        done = 1'b1;
        rd_data = rdata;
        rready <= 1'b0;
      end else begin
        r = next_rand();
        rready <= r[0] | r[1];
      end
    end
    if (!done) begin
      $display("timeout: read of %h got no response within %0d cycles", rd_addr, cnt);
      tb_errors++;
      hung = 1'b1;
    end
  endtask

  task automatic finish_run();
    $display("tests 6, checks %0d, errors %0d", checks, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin
    lcg_state = 64'd93477;
    tb_errors = 0;
    hung      = 1'b0;
    rst       = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    awid      = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    arid      = '0;
    rready    = 1'b0;
    test_id   = 0;
    test_end  = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);

    start_test(1);
    axi_read(timer_addr(MTIMECMP_LO), rval);
    axi_read(timer_addr(MTIMECMP_HI), rval);
    axi_read(msip_addr(MSIP_REG), rval);
    end_test();

    start_test(2);
    repeat (24) begin
      rnd = next_rand();
      case (rnd[1:0])
        2'd0:    addr = timer_addr(MTIMECMP_LO);
        2'd1:    addr = timer_addr(MTIMECMP_HI);
        default: addr = msip_addr(MSIP_REG);
      endcase
      axi_write(addr, next_rand());
      axi_read(addr, rval);
    end
    end_test();

    start_test(3);
    repeat (6) begin
      axi_read(timer_addr(MTIME_LO), rval);
      rnd = next_rand();
      idle(rnd[3:0]);
      axi_read(timer_addr(MTIME_HI), rval);
    end
    end_test();

    // Compare a few ticks ahead of the current mtime
    start_test(4);
    axi_write(timer_addr(MTIMECMP_HI), '1);
    axi_read(timer_addr(MTIME_LO), rval);
    rnd = next_rand();
    axi_write(timer_addr(MTIMECMP_LO), rval + 32'd8 + rnd[2:0]);
    axi_write(timer_addr(MTIMECMP_HI), 32'h0);
    n = 0;
    while (!mtimer_irq && !hung && n < 400) begin
      @(posedge clk);
      n++;
    end
    if (!mtimer_irq && !hung) begin
      $display("timeout: mtimer_irq did not rise within %0d cycles", n);
      tb_errors++;
    end
    idle(20);
    axi_write(timer_addr(MTIMECMP_HI), '1);
    idle(4);
    axi_read(timer_addr(MTIMECMP_HI), rval);
    end_test();

    start_test(5);
    repeat (8) begin
      rnd = next_rand();
      axi_write(msip_addr(MSIP_REG), rnd);
      idle(rnd[10:8]);
      axi_read(msip_addr(MSIP_REG), rval);
    end
    // A set bit at another offset must leave msip clear
    axi_write(msip_addr(MSIP_REG), 32'h0);
    axi_write(msip_addr(16'h0004), 32'h1);
    axi_read(msip_addr(MSIP_REG), rval);
    end_test();

    start_test(6);
    repeat (6) begin
      rnd = next_rand();
      addr = {rnd[31:16], 12'h000, rnd[3:2], 2'b00};
      if (addr[31:16] < 16'd2) addr[31:16] = addr[31:16] + 16'd2;
      axi_write(addr, next_rand());
      axi_read(addr, rval);
    end
    // Registers must be untouched by the unmapped writes
    axi_read(timer_addr(MTIMECMP_LO), rval);
    axi_read(timer_addr(MTIMECMP_HI), rval);
    axi_read(msip_addr(MSIP_REG), rval);
    end_test();

    idle(2);
    finish_run();
  end

endmodule

//--- src.f
clint_pkg.sv
resp_hold.sv
axi_mtimer.sv
axi_msip.sv
clint_demux.sv
clint_top.sv
clint_checker.sv
clint_props.sv
tb_clint.sv

//--- Bender.yml
package:
  name: clint

sources:
  - clint_pkg.sv
  - resp_hold.sv
  - axi_mtimer.sv
  - axi_msip.sv
  - clint_demux.sv
  - clint_top.sv
  - target: test
    files:
      - clint_checker.sv
      - clint_props.sv
      - tb_clint.sv
